//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_tia_audio
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
src/tia_audio_pkg.sv
src/audio_reg_file.sv
src/freq_divider.sv
src/poly_waveform.sv
src/sample_mixer_fsm.sv
src/tia_audio_top.sv
dv/audio_checker.sv
dv/tb_tia_audio.sv

//--- dv/audio_checker.sv
`timescale 1ns/1ns

module audio_checker (
	input logic CLK_30,
	input logic arst_n,
	input logic wr_en,
	input tia_audio_pkg::reg_wr_t wr,
	input logic aud0,
	input logic aud1,
	input tia_audio_pkg::audio_sample_t smp,
	input logic smp_valid,
	input logic smp_ready,
	input logic [7:0] overrun,
	output int errors,
	output int checks,
	output int samples
);
	import tia_audio_pkg::*;

	localparam int st_idle = 0;
	localparam int st_compute = 1;
	localparam int st_send = 2;

	chan_cfg_t cfg [2];
	logic restart [2];
	logic [8:0] sr [2];  // poly state, low bits only
	int since [2];  // cycles since restart
	int idx [2];  // steps since restart
	logic exp_aud [2];
	logic step0_d;
	int mstate;
	logic [7:0] exp_ovr;
	audio_sample_t exp_smp;
	logic [7:0] wr_word;

	assign wr_word = wr.data;

	// ########################################
	// reference functions
	// ########################################
	function automatic logic wave_out(input logic [3:0] c, input logic [8:0] s, input int n);
		case (c)
			4'h1, 4'h7, 4'h8, 4'h9: return s[0];
			4'h4, 4'h5: return n % 2 == 0;
			4'hc, 4'hd: return n % 6 < 3;
			4'h6, 4'ha: return n % sq31_len < sq31_high;
			default: return 1'b1;
		endcase
	endfunction

	// fibonacci shift, feedback into the top bit of each width
	function automatic logic [8:0] wave_next(input logic [3:0] c, input logic [8:0] s);
		case (c)
			4'h1: return {5'd0, s[0] ^ s[1], s[3:1]};
			4'h7, 4'h9: return {4'd0, s[0] ^ s[2], s[4:1]};
			4'h8: return {s[0] ^ s[4], s[8:1]};
			default: return s;
		endcase
	endfunction

	function automatic logic [level_w-1:0] mix_level(input logic [3:0] v0, input logic [3:0] v1,
		input logic b0, input logic b1);
		return level_w'(b0 ? v0 : 4'd0) + level_w'(b1 ? v1 : 4'd0);
	endfunction

	task automatic compare(input string what, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// ########################################
	// cycle model, sampled mid-cycle
	// ########################################
	always @(negedge CLK_30) begin
		if (!arst_n) begin
			cfg = '{default: '0};
			restart = '{default: 1'b0};
			sr = '{default: '1};
			since = '{default: 1};  // count starts at zero, first cycle steps
			idx = '{default: 0};
			exp_aud = '{default: 1'b1};
			step0_d = 1'b0;
			mstate = st_idle;
			exp_ovr = '0;
		end
		compare("aud0", {7'd0, aud0}, {7'd0, exp_aud[0]});
		compare("aud1", {7'd0, aud1}, {7'd0, exp_aud[1]});
		compare("smp_valid", {7'd0, smp_valid}, {7'd0, mstate == st_send});
		compare("overrun", overrun, exp_ovr);
		if (mstate == st_send)
			compare("sample", {1'b0, smp}, {1'b0, exp_smp});
		if (arst_n) begin
			if (step0_d && mstate != st_idle && exp_ovr != 8'hff)
				exp_ovr++;  // step lost while busy
			case (mstate)
				st_idle: if (step0_d) mstate = st_compute;
				st_compute: begin
					exp_smp.level = mix_level(cfg[0].audv, cfg[1].audv, exp_aud[0], exp_aud[1]);
					exp_smp.aud0 = exp_aud[0];
					exp_smp.aud1 = exp_aud[1];
					mstate = st_send;
				end
				default: if (smp_ready) begin
					samples++;
					mstate = st_idle;
				end
			endcase
			step0_d = 1'b0;
			for (int ch = 0; ch < 2; ch++) begin
				if (restart[ch]) begin
					since[ch] = 0;
					sr[ch] = '1;
					idx[ch] = 0;
				end
				if (since[ch] > 0 && since[ch] % (int'(cfg[ch].audf) + 1) == 0) begin
					exp_aud[ch] = wave_out(cfg[ch].audc, sr[ch], idx[ch]);
					sr[ch] = wave_next(cfg[ch].audc, sr[ch]);
					idx[ch]++;
					if (ch == 0)
						step0_d = 1'b1;
				end
				since[ch]++;
			end
			restart[0] = wr_en && (wr.addr == addr_audc0 || wr.addr == addr_audf0);
			restart[1] = wr_en && (wr.addr == addr_audc1 || wr.addr == addr_audf1);
			if (wr_en) begin
				case (wr.addr)
					addr_audc0: cfg[0].audc = wr_word[3:0];
					addr_audc1: cfg[1].audc = wr_word[3:0];
					addr_audf0: cfg[0].audf = wr_word[4:0];
					addr_audf1: cfg[1].audf = wr_word[4:0];
					addr_audv0: cfg[0].audv = wr_word[3:0];
					addr_audv1: cfg[1].audv = wr_word[3:0];
					default: ;
				endcase
			end
		end
	end

endmodule

//--- dv/tb_tia_audio.sv
`timescale 1ns/1ns

module tb_tia_audio;
	import tia_audio_pkg::*;

	localparam int mode_samples = 32;
	localparam int hold_samples = 40;
	localparam int restart_samples = 10;
	localparam int max_period = 32;
	localparam logic [15:0] ch1_codes = 16'h9871;  // poly4, poly5, poly9, poly5
	// worst case wait per phase, plus writes and resets
	localparam int timeout_cycles = 16 * (mode_samples * max_period + 16)
		+ hold_samples * 24 + 4 * restart_samples * max_period + 500;

	logic CLK_30 = 1'b0;
	logic arst_n;
	logic wr_en;
	reg_wr_t wr;
	logic aud0;
	logic aud1;
	audio_sample_t smp;
	logic smp_valid;
	logic smp_ready;
	logic [7:0] overrun;
	int errors;
	int checks;
	int samples;
	int tb_errors;
	int cycles;
	int target;
	logic [15:0] lfsr;
	logic [7:0] f;
	logic [7:0] ovr_start;

	tia_audio_top uut (.*);
	audio_checker chk (.*);

	initial begin
		forever #50 CLK_30 = ~CLK_30;
	end

	always @(posedge CLK_30) begin
		cycles++;
		if (cycles > timeout_cycles) begin
			$display("timeout, samples stopped arriving within %0d cycles", timeout_cycles);
			$display("Errors found");
			$finish;
		end
	end

	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hb400 : lfsr >> 1;  // galois
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic next_cycle();
		@(posedge CLK_30);
		#10;
	endtask

	task automatic write_reg(input reg_addr_t addr, input logic [7:0] data);
		wr_en = 1'b1;
		wr = {addr, data};
		next_cycle();
		wr_en = 1'b0;
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		repeat (8) next_cycle();
		arst_n = 1'b1;
	endtask

	task automatic wait_samples(input int n);
		target = samples + n;
		while (samples < target)
			next_cycle();
	endtask

	initial begin
		arst_n = 1'b0;
		wr_en = 1'b0;
		wr = '0;
		smp_ready = 1'b1;
		lfsr = 16'd77;
		tb_errors = 0;
		apply_reset();

		// ch0 through every code, ch1 on poly modes at its own rate
		write_reg(addr_audf1, 8'd11);
		for (int code = 0; code < 16; code++) begin
			write_reg(addr_audv0, take_bits(4));
			write_reg(addr_audv1, take_bits(4));
			write_reg(addr_audc1, 8'(ch1_codes[4 * (code % 4) +: 4]));
			f = take_bits(5);
			if (f == 8'd11)
				f = 8'd3;
			write_reg(addr_audf0, f);
			write_reg(addr_audc0, 8'(code));
			wait_samples(mode_samples);
		end

		// back-pressure with fast ch0 steps
		apply_reset();
		write_reg(addr_audv0, take_bits(4));
		write_reg(addr_audv1, take_bits(4));
		write_reg(addr_audf1, 8'd4);
		write_reg(addr_audc1, 8'h7);
		write_reg(addr_audf0, 8'd1);
		write_reg(addr_audc0, 8'h8);
		ovr_start = overrun;
		target = samples + hold_samples;
		while (samples < target) begin
			smp_ready = take_bits(2) == 8'd3;  // mostly low
			next_cycle();
		end
		smp_ready = 1'b1;
		if (overrun == ovr_start) begin
			$display("overrun never moved while ready was held low");
			tb_errors++;
		end

		// rewrite audc mid pattern
		write_reg(addr_audf0, 8'd2);
		write_reg(addr_audc0, 8'h6);
		wait_samples(restart_samples);
		write_reg(addr_audc0, 8'h6);
		wait_samples(restart_samples);
		write_reg(addr_audc0, 8'h8);
		wait_samples(restart_samples);
		write_reg(addr_audc0, 8'h8);
		wait_samples(restart_samples);

		$display("checks %0d, samples %0d, mismatches %0d, other errors %0d",
			checks, samples, errors, tb_errors);
		if (errors + tb_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- src/audio_reg_file.sv
`timescale 1ns/1ns

module audio_reg_file (
	input logic CLK_30,
	input logic arst_n,
	input logic wr_en,
	input tia_audio_pkg::reg_wr_t wr,
	output tia_audio_pkg::chan_cfg_t cfg0,
	output tia_audio_pkg::chan_cfg_t cfg1,
	output logic restart0,
	output logic restart1
);
	import tia_audio_pkg::*;

	logic wr_ch0;  // audc0 or audf0 written
	logic wr_ch1;

	assign wr_ch0 = wr_en && (wr.addr == addr_audc0 || wr.addr == addr_audf0);
	assign wr_ch1 = wr_en && (wr.addr == addr_audc1 || wr.addr == addr_audf1);

	always_ff @(posedge CLK_30 or negedge arst_n) begin
		if (!arst_n) begin
			cfg0 <= '0;
			cfg1 <= '0;
		end else if (wr_en) begin
			case (wr.addr)
				addr_audc0: cfg0.audc <= wr.data.ctl.val;
				addr_audc1: cfg1.audc <= wr.data.ctl.val;
				addr_audf0: cfg0.audf <= wr.data.freq.val;
				addr_audf1: cfg1.audf <= wr.data.freq.val;
				addr_audv0: cfg0.audv <= wr.data.ctl.val;
				addr_audv1: cfg1.audv <= wr.data.ctl.val;
				default: ;  // 6 and 7 unmapped
			endcase
		end
	end

	// one cycle after the write edge
	always_ff @(posedge CLK_30 or negedge arst_n) begin
		if (!arst_n) begin
			restart0 <= 1'b0;
			restart1 <= 1'b0;
		end else begin
			restart0 <= wr_ch0;
			restart1 <= wr_ch1;
		end
	end

	// back to back restarts need back to back writes
	a_restart0_pulse: assert property (
		@(posedge CLK_30) disable iff (!arst_n)
		restart0 && $past(restart0) |-> $past(wr_en) && $past(wr_en, 2)
	) else $error("restart0 held high without a write in each cycle");

endmodule

//--- src/freq_divider.sv
`timescale 1ns/1ns

module freq_divider (
	input logic CLK_30,
	input logic arst_n,
	input logic [tia_audio_pkg::audf_w-1:0] audf,
	input logic restart,
	output logic step
);
	import tia_audio_pkg::*;

	logic [audf_w-1:0] cnt;
	logic tc;

	assign tc = (cnt == '0);

	// first step lands audf+1 cycles after restart
	always_ff @(posedge CLK_30 or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (restart || tc) begin
			cnt <= audf;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	assign step = tc && !restart;  // no step while reloading

	// audf only moves through a write, and every write restarts the count
	a_cnt_range: assert property (
		@(posedge CLK_30) disable iff (!arst_n)
		!restart |-> cnt <= audf
	) else $error("divider count above the programmed audf");

endmodule

//--- src/poly_waveform.sv
`timescale 1ns/1ns

module poly_waveform (
	input logic CLK_30,
	input logic arst_n,
	input logic [tia_audio_pkg::audc_w-1:0] audc,
	input logic step,
	input logic restart,
	output logic wave_bit
);
	import tia_audio_pkg::*;

	mode_t mode;
	logic [poly4_w-1:0] poly4;
	logic [poly5_w-1:0] poly5;
	logic [poly9_w-1:0] poly9;
	logic div2;
	logic [2:0] div6_idx;
	logic [4:0] sq_idx;
	logic gen_bit;

	assign mode = mode_of(audc);

	// ########################################
	// current bit of the selected generator
	// ########################################
	always_comb begin
		case (mode)
			mode_poly4: gen_bit = poly4[0];
			mode_poly5: gen_bit = poly5[0];
			mode_poly9: gen_bit = poly9[0];
			mode_div2: gen_bit = div2;
			mode_div6: gen_bit = (div6_idx < 3'(div6_high));
			mode_sq31: gen_bit = (sq_idx < 5'(sq31_high));
			default: gen_bit = 1'b1;
		endcase
	end

	// ########################################
	// generator state
	// ########################################
	always_ff @(posedge CLK_30 or negedge arst_n) begin
		if (!arst_n) begin
			poly4 <= '1;
			poly5 <= '1;
			poly9 <= '1;
			div2 <= 1'b1;
			div6_idx <= '0;
			sq_idx <= '0;
		end else if (restart) begin
			poly4 <= '1;  // seed
			poly5 <= '1;
			poly9 <= '1;
			div2 <= 1'b1;
			div6_idx <= '0;
			sq_idx <= '0;
		end else if (step) begin
			case (mode)
				mode_poly4: poly4 <= {poly4[0] ^ poly4[1], poly4[poly4_w-1:1]};
				mode_poly5: poly5 <= {poly5[0] ^ poly5[2], poly5[poly5_w-1:1]};
				mode_poly9: poly9 <= {poly9[0] ^ poly9[4], poly9[poly9_w-1:1]};
				mode_div2: div2 <= ~div2;
				mode_div6: begin
					if (div6_idx == 3'(div6_len - 1))
						div6_idx <= '0;
					else
						div6_idx <= div6_idx + 3'd1;
				end
				mode_sq31: begin
					if (sq_idx == 5'(sq31_len - 1))
						sq_idx <= '0;
					else
						sq_idx <= sq_idx + 5'd1;
				end
				default: ;  // constant holds no state
			endcase
		end
	end

	// output flop, one cycle behind the step
	always_ff @(posedge CLK_30 or negedge arst_n) begin
		if (!arst_n)
			wave_bit <= 1'b1;
		else if (step && !restart)
			wave_bit <= gen_bit;
	end

	a_sq_idx: assert property (
		@(posedge CLK_30) disable iff (!arst_n)
		sq_idx < 5'(sq31_len)
	) else $error("square index ran past the pattern length");

endmodule

//--- src/sample_mixer_fsm.sv
`timescale 1ns/1ns

module sample_mixer_fsm (
	input logic CLK_30,
	input logic arst_n,
	input logic step0,
	input logic bit0,
	input logic bit1,
	input logic [tia_audio_pkg::audv_w-1:0] audv0,
	input logic [tia_audio_pkg::audv_w-1:0] audv1,
	output tia_audio_pkg::audio_sample_t smp,
	output logic smp_valid,
	input logic smp_ready,
	output logic [7:0] overrun
);
	import tia_audio_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		COMPUTE,
		SEND
	} state_t;

	state_t state;
	logic step0_d;  // waveform has settled by now
	logic drop;
	logic [level_w-1:0] mix;

	assign drop = step0_d && (state != IDLE);
	assign mix = (bit0 ? level_w'(audv0) : '0) + (bit1 ? level_w'(audv1) : '0);

	// ########################################
	// control
	// ########################################
	always_ff @(posedge CLK_30 or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			step0_d <= 1'b0;
			smp_valid <= 1'b0;
			overrun <= '0;
		end else begin
			step0_d <= step0;
			case (state)
				IDLE: if (step0_d) state <= COMPUTE;
				COMPUTE: begin
					state <= SEND;
					smp_valid <= 1'b1;
				end
				SEND: begin
					if (smp_ready) begin
						state <= IDLE;
						smp_valid <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
			if (drop && overrun != 8'hff)
				overrun <= overrun + 8'd1;  // saturates
		end
	end

	// payload latched at the end of COMPUTE
	always_ff @(posedge CLK_30) begin
		if (state == COMPUTE) begin
			smp.level <= mix;
			smp.aud0 <= bit0;
			smp.aud1 <= bit1;
		end
	end

	a_smp_hold: assert property (
		@(posedge CLK_30) disable iff (!arst_n)
		smp_valid && !smp_ready |=> smp_valid && $stable(smp)
	) else $error("sample changed while waiting for ready");

endmodule

//--- src/tia_audio_pkg.sv
package tia_audio_pkg;

	// register widths
	localparam int audc_w = 4;
	localparam int audf_w = 5;
	localparam int audv_w = 4;
	localparam int level_w = 5;  // 15 + 15 fits

	// poly and pattern lengths
	localparam int poly4_w = 4;
	localparam int poly5_w = 5;
	localparam int poly9_w = 9;
	localparam int div6_len = 6;
	localparam int div6_high = 3;
	localparam int sq31_high = 18;
	localparam int sq31_len = 31;

	// ########################################
	// host write port
	// ########################################
	typedef logic [2:0] reg_addr_t;

	localparam reg_addr_t addr_audc0 = 3'd0;
	localparam reg_addr_t addr_audc1 = 3'd1;
	localparam reg_addr_t addr_audf0 = 3'd2;
	localparam reg_addr_t addr_audf1 = 3'd3;
	localparam reg_addr_t addr_audv0 = 3'd4;
	localparam reg_addr_t addr_audv1 = 3'd5;

	typedef struct packed {
		logic [3:0] rsvd;
		logic [audc_w-1:0] val;  // audc or audv
	} reg_ctl_t;

	typedef struct packed {
		logic [2:0] rsvd;
		logic [audf_w-1:0] val;
	} reg_freq_t;

	typedef union packed {
		reg_ctl_t ctl;
		reg_freq_t freq;
	} reg_data_u;

	typedef struct packed {
		reg_addr_t addr;
		reg_data_u data;
	} reg_wr_t;

	typedef struct packed {
		logic [audc_w-1:0] audc;
		logic [audf_w-1:0] audf;
		logic [audv_w-1:0] audv;
	} chan_cfg_t;

	typedef struct packed {
		logic [level_w-1:0] level;
		logic aud0;
		logic aud1;
	} audio_sample_t;

	// ########################################
	// waveform modes
	// ########################################
	typedef logic [2:0] mode_t;

	localparam mode_t mode_const = 3'd0;
	localparam mode_t mode_poly4 = 3'd1;
	localparam mode_t mode_div2 = 3'd2;
	localparam mode_t mode_poly5 = 3'd3;
	localparam mode_t mode_poly9 = 3'd4;
	localparam mode_t mode_div6 = 3'd5;
	localparam mode_t mode_sq31 = 3'd6;

	function automatic mode_t mode_of(input logic [audc_w-1:0] audc);
		case (audc)
			4'h1: return mode_poly4;
			4'h4, 4'h5: return mode_div2;
			4'h7, 4'h9: return mode_poly5;
			4'h8: return mode_poly9;
			4'hc, 4'hd: return mode_div6;
			4'h6, 4'ha: return mode_sq31;
			default: return mode_const;  // 0, b and the chained codes
		endcase
	endfunction

endpackage

//--- src/tia_audio_top.sv
`timescale 1ns/1ns

module tia_audio_top (
	input logic CLK_30,
	input logic arst_n,
	input logic wr_en,
	input tia_audio_pkg::reg_wr_t wr,
	output logic aud0,
	output logic aud1,
	output tia_audio_pkg::audio_sample_t smp,
	output logic smp_valid,
	input logic smp_ready,
	output logic [7:0] overrun
);
	import tia_audio_pkg::*;

	chan_cfg_t cfg0;
	chan_cfg_t cfg1;
	logic restart0;
	logic restart1;
	logic step0;
	logic step1;

	audio_reg_file u_regs (
		.CLK_30(CLK_30),
		.arst_n(arst_n),
		.wr_en(wr_en),
		.wr(wr),
		.cfg0(cfg0),
		.cfg1(cfg1),
		.restart0(restart0),
		.restart1(restart1)
	);

	// ########################################
	// channel 0
	// ########################################
	freq_divider u_div0 (.CLK_30(CLK_30), .arst_n(arst_n), .audf(cfg0.audf),
		.restart(restart0), .step(step0));

	poly_waveform u_wave0 (.CLK_30(CLK_30), .arst_n(arst_n), .audc(cfg0.audc),
		.step(step0), .restart(restart0), .wave_bit(aud0));

	// ########################################
	// channel 1
	// ########################################
	freq_divider u_div1 (.CLK_30(CLK_30), .arst_n(arst_n), .audf(cfg1.audf),
		.restart(restart1), .step(step1));

	poly_waveform u_wave1 (.CLK_30(CLK_30), .arst_n(arst_n), .audc(cfg1.audc),
		.step(step1), .restart(restart1), .wave_bit(aud1));

	// samples paced by channel 0
	sample_mixer_fsm u_mixer (
		.CLK_30(CLK_30),
		.arst_n(arst_n),
		.step0(step0),
		.bit0(aud0),
		.bit1(aud1),
		.audv0(cfg0.audv),
		.audv1(cfg1.audv),
		.smp(smp),
		.smp_valid(smp_valid),
		.smp_ready(smp_ready),
		.overrun(overrun)
	);

endmodule
